//--- design/fp_add_pkg.sv
// fp_add_pkg: shared types and constants for the binary32 adder pipeline
package fp_add_pkg;

   // binary32 field widths
   localparam int exp_w  = 8;
   localparam int frac_w = 23;
   localparam int word_w = 32;

   // aligned fraction: hidden bit, 23 fraction bits, guard, round, sticky
   localparam int sum_w = 27;

   // the only NaN the adder ever produces
   localparam logic [word_w-1:0] canonical_nan = 32'h7fc0_0000;

   // operation select, sub flips the sign of operand b
   typedef enum logic {
      add = 1'b0,
      sub = 1'b1
   } fp_op_e;

   // RISC-V frm encodings
   typedef enum logic [2:0] {
      rne = 3'b000,
      rtz = 3'b001,
      rdn = 3'b010,
      rup = 3'b011,
      rmm = 3'b100
   } fp_rm_e;

   // operand class, subnormals are folded into zero
   typedef enum logic [2:0] {
      zero   = 3'd0,
      normal = 3'd1,
      inf    = 3'd2,
      qnan   = 3'd3,
      snan   = 3'd4
   } fp_class_e;

   // exception flags, no divide-by-zero for an adder
   typedef struct packed {
      logic nv;
      logic of;
      logic uf;
      logic nx;
   } fp_flags_t;

endpackage

//--- design/fp_align_if.sv
// fp_align_if: aligned operand bundle passed from the decode step to the execute step
`timescale 1ns/1ps

interface fp_align_if;

   logic valid;
   // sign_a belongs to frac_big after the swap
   logic sign_a;
   // effective sign of the smaller operand, sub opcode already applied
   logic sign_b;
   logic [fp_add_pkg::exp_w-1:0] exp_max;
   logic [fp_add_pkg::sum_w-1:0] frac_big;
   // right shifted into alignment, lost bits folded into bit 0
   logic [fp_add_pkg::sum_w-1:0] frac_small;
   fp_add_pkg::fp_rm_e rm;
   // result already known from the operand classes
   logic special;
   logic [fp_add_pkg::word_w-1:0] special_word;
   logic special_nv;

   modport src (
      output valid, sign_a, sign_b, exp_max, frac_big, frac_small,
      output rm, special, special_word, special_nv
   );

   modport dst (
      input valid, sign_a, sign_b, exp_max, frac_big, frac_small,
      input rm, special, special_word, special_nv
   );

endinterface

//--- design/fp_sum_if.sv
// fp_sum_if: raw sum bundle passed from the execute step to the result step
`timescale 1ns/1ps

interface fp_sum_if;

   logic valid;
   logic sign;
   logic [fp_add_pkg::exp_w-1:0] exp_max;
   // unnormalized magnitude, same layout as the aligned fractions
   logic [fp_add_pkg::sum_w-1:0] frac;
   // carry out of the fraction add, weight 2.0
   logic carry;
   fp_add_pkg::fp_rm_e rm;
   logic special;
   logic [fp_add_pkg::word_w-1:0] special_word;
   logic special_nv;

   modport src (
      output valid, sign, exp_max, frac, carry,
      output rm, special, special_word, special_nv
   );

   modport dst (
      input valid, sign, exp_max, frac, carry,
      input rm, special, special_word, special_nv
   );

endinterface

//--- design/fp_rounder.sv
// fp_rounder: rounds a 24-bit significand using guard and sticky in any RISC-V rounding mode
`timescale 1ns/1ps

module fp_rounder (
   input  fp_add_pkg::fp_rm_e  rm,
   input  logic                sign,
   // [25:2] significand with hidden bit, [1] guard, [0] sticky
   input  logic [25:0]         frac_in,
   output logic [23:0]         frac_out,
   output logic                carry,
   output logic                inexact
);

   logic lsb;
   logic guard;
   logic sticky;
   logic round_up;

   assign lsb    = frac_in[2];
   assign guard  = frac_in[1];
   assign sticky = frac_in[0];

   always_comb begin
      case (rm)
         // ties go to the even neighbour
         fp_add_pkg::rne: round_up = guard & (sticky | lsb);
         fp_add_pkg::rtz: round_up = 1'b0;
         // toward -inf grows only negative magnitudes
         fp_add_pkg::rdn: round_up = sign & (guard | sticky);
         fp_add_pkg::rup: round_up = ~sign & (guard | sticky);
         // ties away from zero
         fp_add_pkg::rmm: round_up = guard;
         // reserved encodings fall back to nearest even
         default:         round_up = guard & (sticky | lsb);
      endcase
   end

   // a carry here means the significand wrapped to 1.0 of the next binade
   assign {carry, frac_out} = {1'b0, frac_in[25:2]} + {24'd0, round_up};

   assign inexact = guard | sticky;

endmodule

//--- design/fp_add_decode.sv
// fp_add_decode: unpacks and classifies both operands, resolves specials, aligns the fractions
`timescale 1ns/1ps

module fp_add_decode (
   input  logic                              clk,
   input  logic                              arst_n,
   input  logic                              in_valid,
   input  logic [fp_add_pkg::word_w-1:0]     op_a,
   input  logic [fp_add_pkg::word_w-1:0]     op_b,
   input  fp_add_pkg::fp_op_e                op,
   input  fp_add_pkg::fp_rm_e                rm,
   fp_align_if.src                           align
);

   logic sign_a;
   logic sign_b;
   logic [fp_add_pkg::exp_w-1:0] exp_a;
   logic [fp_add_pkg::exp_w-1:0] exp_b;
   logic [fp_add_pkg::frac_w-1:0] frac_a;
   logic [fp_add_pkg::frac_w-1:0] frac_b;
   fp_add_pkg::fp_class_e class_a;
   fp_add_pkg::fp_class_e class_b;
   logic [fp_add_pkg::sum_w-1:0] mant_a;
   logic [fp_add_pkg::sum_w-1:0] mant_b;
   logic a_big;
   logic [fp_add_pkg::exp_w-1:0] exp_small;
   logic [fp_add_pkg::exp_w-1:0] exp_diff;
   logic [4:0] shamt;
   logic [2*fp_add_pkg::sum_w-1:0] shifted;
   logic [fp_add_pkg::sum_w-1:0] mant_small;
   logic spec;
   logic [fp_add_pkg::word_w-1:0] spec_word;
   logic spec_nv;

   function automatic fp_add_pkg::fp_class_e classify(
      input logic [fp_add_pkg::exp_w-1:0]  e,
      input logic [fp_add_pkg::frac_w-1:0] f
   );
      fp_add_pkg::fp_class_e c;
      c = fp_add_pkg::normal;
      // subnormal reads as zero
      if (e == '0)
         c = fp_add_pkg::zero;
      else if (e == '1) begin
         if (f == '0)
            c = fp_add_pkg::inf;
         else if (f[fp_add_pkg::frac_w-1])
            c = fp_add_pkg::qnan;
         else
            c = fp_add_pkg::snan;
      end
      return c;
   endfunction

   // unpack, b takes the sub opcode on its sign
   assign {sign_a, exp_a, frac_a} = op_a;
   assign sign_b = op_b[fp_add_pkg::word_w-1] ^ (op == fp_add_pkg::sub);
   assign exp_b  = op_b[fp_add_pkg::word_w-2 -: fp_add_pkg::exp_w];
   assign frac_b = op_b[fp_add_pkg::frac_w-1:0];
   assign class_a = classify(exp_a, frac_a);
   assign class_b = classify(exp_b, frac_b);

   // significands with hidden bit, three empty low bits for guard, round, sticky
   assign mant_a = (class_a == fp_add_pkg::normal) ? {1'b1, frac_a, 3'b000} : '0;
   assign mant_b = (class_b == fp_add_pkg::normal) ? {1'b1, frac_b, 3'b000} : '0;

   // magnitude compare on exponent then fraction, zeros compare as all zero
   assign a_big = {exp_a, (class_a == fp_add_pkg::zero) ? '0 : frac_a} >=
                  {exp_b, (class_b == fp_add_pkg::zero) ? '0 : frac_b};

   assign exp_small = a_big ? exp_b : exp_a;
   assign exp_diff  = (a_big ? exp_a : exp_b) - exp_small;
   // anything past 27 places lands entirely in sticky
   assign shamt = (exp_diff > 8'd27) ? 5'd27 : exp_diff[4:0];
   assign shifted = {(a_big ? mant_b : mant_a), {fp_add_pkg::sum_w{1'b0}}} >> shamt;
   // upper half is the aligned value, any bit left in the lower half is sticky
   assign mant_small = {shifted[2*fp_add_pkg::sum_w-1:fp_add_pkg::sum_w+1],
                        shifted[fp_add_pkg::sum_w] | (|shifted[fp_add_pkg::sum_w-1:0])};

   // results fixed by class alone
   always_comb begin
      spec      = 1'b0;
      spec_word = '0;
      spec_nv   = 1'b0;
      if (class_a == fp_add_pkg::qnan || class_a == fp_add_pkg::snan ||
          class_b == fp_add_pkg::qnan || class_b == fp_add_pkg::snan) begin
         spec      = 1'b1;
         spec_word = fp_add_pkg::canonical_nan;
         spec_nv   = (class_a == fp_add_pkg::snan) || (class_b == fp_add_pkg::snan);
      end else if (class_a == fp_add_pkg::inf && class_b == fp_add_pkg::inf) begin
         spec = 1'b1;
         if (sign_a != sign_b) begin
            // inf - inf is invalid
            spec_word = fp_add_pkg::canonical_nan;
            spec_nv   = 1'b1;
         end else
            spec_word = {sign_a, {fp_add_pkg::exp_w{1'b1}}, {fp_add_pkg::frac_w{1'b0}}};
      end else if (class_a == fp_add_pkg::inf) begin
         spec      = 1'b1;
         spec_word = {sign_a, {fp_add_pkg::exp_w{1'b1}}, {fp_add_pkg::frac_w{1'b0}}};
      end else if (class_b == fp_add_pkg::inf) begin
         spec      = 1'b1;
         spec_word = {sign_b, {fp_add_pkg::exp_w{1'b1}}, {fp_add_pkg::frac_w{1'b0}}};
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n)
         align.valid <= 1'b0;
      else
         align.valid <= in_valid;
   end

   // payload loads only with a valid operation
   always_ff @(posedge clk) begin
      if (in_valid) begin
         align.sign_a       <= a_big ? sign_a : sign_b;
         align.sign_b       <= a_big ? sign_b : sign_a;
         align.exp_max      <= a_big ? exp_a : exp_b;
         align.frac_big     <= a_big ? mant_a : mant_b;
         align.frac_small   <= mant_small;
         align.rm           <= rm;
         align.special      <= spec;
         align.special_word <= spec_word;
         align.special_nv   <= spec_nv;
      end
   end

endmodule

//--- design/fp_add_execute.sv
// fp_add_execute: adds or subtracts the aligned fractions and registers the raw sum with carry
`timescale 1ns/1ps

module fp_add_execute (
   input  logic       clk,
   input  logic       arst_n,
   fp_align_if.dst    align,
   fp_sum_if.src      sum
);

   logic eff_sub;
   logic [fp_add_pkg::sum_w:0] raw;
   logic res_sign;

   always_comb begin
      // differing effective signs mean a true subtraction
      eff_sub = align.sign_a ^ align.sign_b;
      // frac_big is never below frac_small, so the difference stays positive
      if (eff_sub)
         raw = {1'b0, align.frac_big} - {1'b0, align.frac_small};
      else
         raw = {1'b0, align.frac_big} + {1'b0, align.frac_small};
      // exact cancellation is -0 only when rounding down
      if (eff_sub && raw == '0)
         res_sign = (align.rm == fp_add_pkg::rdn);
      else
         res_sign = align.sign_a;
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n)
         sum.valid <= 1'b0;
      else
         sum.valid <= align.valid;
   end

   always_ff @(posedge clk) begin
      if (align.valid) begin
         sum.sign         <= res_sign;
         sum.exp_max      <= align.exp_max;
         sum.frac         <= raw[fp_add_pkg::sum_w-1:0];
         // top bit only ever set on an add
         sum.carry        <= raw[fp_add_pkg::sum_w];
         sum.rm           <= align.rm;
         // specials ride along untouched
         sum.special      <= align.special;
         sum.special_word <= align.special_word;
         sum.special_nv   <= align.special_nv;
      end
   end

endmodule

//--- design/fp_add_result.sv
// fp_add_result: normalizes, rounds and range checks the sum, then packs the word and flags
`timescale 1ns/1ps

module fp_add_result (
   input  logic                           clk,
   input  logic                           arst_n,
   fp_sum_if.dst                          sum,
   output logic                           out_valid,
   output logic [fp_add_pkg::word_w-1:0]  result,
   output fp_add_pkg::fp_flags_t          flags
);

   logic [fp_add_pkg::sum_w:0] full;
   logic [4:0] lz;
   logic [fp_add_pkg::sum_w-1:0] norm;
   logic [25:0] rnd_in;
   logic signed [9:0] exp_norm;
   logic signed [9:0] exp_fin;
   logic [23:0] rnd_frac;
   logic rnd_carry;
   logic rnd_nx;
   logic [fp_add_pkg::word_w-1:0] word_next;
   fp_add_pkg::fp_flags_t flags_next;

   // leading zero count over the 27-bit sum, 27 when empty
   function automatic logic [4:0] lead_zeros(input logic [fp_add_pkg::sum_w-1:0] v);
      logic [4:0] n;
      logic found;
      n = 5'd0;
      found = 1'b0;
      for (int i = fp_add_pkg::sum_w - 1; i >= 0; i--) begin
         if (!found) begin
            if (v[i])
               found = 1'b1;
            else
               n = n + 5'd1;
         end
      end
      return n;
   endfunction

   assign full = {sum.carry, sum.frac};
   assign lz   = lead_zeros(sum.frac);
   assign norm = sum.frac << lz;

   always_comb begin
      if (sum.carry) begin
         // value is in [2,4), drop one place and keep the lost bits in sticky
         rnd_in   = {full[fp_add_pkg::sum_w:3], |full[2:0]};
         exp_norm = $signed({2'b00, sum.exp_max}) + 10'sd1;
      end else begin
         // cancellation may leave leading zeros, pull the hidden bit back up
         rnd_in   = {norm[fp_add_pkg::sum_w-1:2], |norm[1:0]};
         exp_norm = $signed({2'b00, sum.exp_max}) - $signed({5'b00000, lz});
      end
   end

   fp_rounder u_rounder (
      .rm       (sum.rm),
      .sign     (sum.sign),
      .frac_in  (rnd_in),
      .frac_out (rnd_frac),
      .carry    (rnd_carry),
      .inexact  (rnd_nx)
   );

   // rounding carry bumps the exponent, the wrapped fraction field is already zero
   assign exp_fin = exp_norm + $signed({9'd0, rnd_carry});

   always_comb begin
      flags_next = '0;
      if (sum.special) begin
         // class-resolved result skips rounding entirely
         word_next     = sum.special_word;
         flags_next.nv = sum.special_nv;
      end else if (!sum.carry && sum.frac == '0) begin
         // exact zero, sign was settled in execute
         word_next = {sum.sign, {(fp_add_pkg::word_w-1){1'b0}}};
      end else if (exp_fin >= 10'sd255) begin
         // overflow saturates to infinity in every mode
         word_next     = {sum.sign, {fp_add_pkg::exp_w{1'b1}}, {fp_add_pkg::frac_w{1'b0}}};
         flags_next.of = 1'b1;
         flags_next.nx = 1'b1;
      end else if (exp_fin < 10'sd1) begin
         // no subnormals, flush to signed zero
         word_next     = {sum.sign, {(fp_add_pkg::word_w-1){1'b0}}};
         flags_next.uf = 1'b1;
         flags_next.nx = 1'b1;
      end else begin
         word_next     = {sum.sign, exp_fin[fp_add_pkg::exp_w-1:0],
                          rnd_frac[fp_add_pkg::frac_w-1:0]};
         flags_next.nx = rnd_nx;
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         out_valid <= 1'b0;
         result    <= '0;
         flags     <= '0;
      end else begin
         out_valid <= sum.valid;
         // hold the last result between operations
         if (sum.valid) begin
            result <= word_next;
            flags  <= flags_next;
         end
      end
   end

endmodule

//--- design/fp_add_top.sv
// fp_add_top: three-step pipelined binary32 adder with plain ports
`timescale 1ns/1ps

module fp_add_top (
   input  logic                           clk,
   input  logic                           arst_n,
   input  logic                           in_valid,
   input  logic [fp_add_pkg::word_w-1:0]  op_a,
   input  logic [fp_add_pkg::word_w-1:0]  op_b,
   input  fp_add_pkg::fp_op_e             op,
   input  fp_add_pkg::fp_rm_e             rm,
   output logic                           out_valid,
   output logic [fp_add_pkg::word_w-1:0]  result,
   output fp_add_pkg::fp_flags_t          flags
);

   // decode to execute
   fp_align_if align_bus ();

   // execute to result
   fp_sum_if sum_bus ();

   // step 1, registered at the first edge
   fp_add_decode u_decode (
      .clk      (clk),
      .arst_n   (arst_n),
      .in_valid (in_valid),
      .op_a     (op_a),
      .op_b     (op_b),
      .op       (op),
      .rm       (rm),
      .align    (align_bus.src)
   );

   // step 2
   fp_add_execute u_execute (
      .clk    (clk),
      .arst_n (arst_n),
      .align  (align_bus.dst),
      .sum    (sum_bus.src)
   );

   // step 3, out_valid three edges after in_valid
   fp_add_result u_result (
      .clk       (clk),
      .arst_n    (arst_n),
      .sum       (sum_bus.dst),
      .out_valid (out_valid),
      .result    (result),
      .flags     (flags)
   );

endmodule

//--- bench/fp_add_properties.sv
// fp_add_properties: pipeline timing and result encoding checks bound onto the adder top level
`timescale 1ns/1ps

module fp_add_properties (
   input logic                           clk,
   input logic                           arst_n,
   input logic                           in_valid,
   input logic                           out_valid,
   input logic [fp_add_pkg::word_w-1:0]  result,
   input fp_add_pkg::fp_flags_t          flags
);

   // number of failed assertions, read by the testbench at the end
   int fail_count = 0;

   // no result may leave while reset is held
   idle_in_reset: assert property (@(posedge clk) !arst_n |-> !out_valid)
      else begin
         fail_count++;
         $error("out_valid high while reset is asserted");
      end

   // fixed latency of three edges
   latency_three: assert property (@(posedge clk) disable iff (!arst_n)
      out_valid == $past(in_valid, 3))
      else begin
         fail_count++;
         $error("out_valid does not follow in_valid by 3 cycles");
      end

   // exponent all ones with a nonzero fraction must be the canonical NaN
   nan_canonical: assert property (@(posedge clk) disable iff (!arst_n)
      (result[30:23] == 8'hff && result[22:0] != 23'd0) |-> result == fp_add_pkg::canonical_nan)
      else begin
         fail_count++;
         $error("non-canonical NaN on result: %h", result);
      end

   // a result cannot be both too large and too small
   range_exclusive: assert property (@(posedge clk) disable iff (!arst_n)
      !(flags.of && flags.uf))
      else begin
         fail_count++;
         $error("overflow and underflow flags set together");
      end

endmodule

bind fp_add_top fp_add_properties u_props (
   .clk       (clk),
   .arst_n    (arst_n),
   .in_valid  (in_valid),
   .out_valid (out_valid),
   .result    (result),
   .flags     (flags)
);

//--- bench/fp_add_tb.sv
// fp_add_tb: directed testbench for the three-step binary32 adder pipeline
`timescale 1ns/1ps

module fp_add_tb;

   // all tests take roughly 200 cycles, the limit leaves a wide margin
   localparam int max_cycles = 2000;

   // expected flag patterns, order is nv of uf nx
   localparam fp_add_pkg::fp_flags_t flags_none = 4'b0000;
   localparam fp_add_pkg::fp_flags_t flags_nx   = 4'b0001;
   localparam fp_add_pkg::fp_flags_t flags_nv   = 4'b1000;
   localparam fp_add_pkg::fp_flags_t flags_ovf  = 4'b0101;
   localparam fp_add_pkg::fp_flags_t flags_unf  = 4'b0011;

   logic                           clk;
   logic                           arst_n;
   logic                           in_valid;
   logic [fp_add_pkg::word_w-1:0]  op_a;
   logic [fp_add_pkg::word_w-1:0]  op_b;
   fp_add_pkg::fp_op_e             op;
   fp_add_pkg::fp_rm_e             rm;
   logic                           out_valid;
   logic [fp_add_pkg::word_w-1:0]  result;
   fp_add_pkg::fp_flags_t          flags;

   int seed;
   int cycles = 0;
   int mismatches = 0;
   int missing = 0;
   int total;
   fp_add_pkg::fp_rm_e modes [5] = '{fp_add_pkg::rne, fp_add_pkg::rtz, fp_add_pkg::rdn,
                                     fp_add_pkg::rup, fp_add_pkg::rmm};

   fp_add_top DUT (
      .clk       (clk),
      .arst_n    (arst_n),
      .in_valid  (in_valid),
      .op_a      (op_a),
      .op_b      (op_b),
      .op        (op),
      .rm        (rm),
      .out_valid (out_valid),
      .result    (result),
      .flags     (flags)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // watchdog
   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= max_cycles) begin
         $display("timeout: the run did not finish within %0d cycles", max_cycles);
         $display("Result: FAILED");
         $finish;
      end
   end

   task automatic check_word(input string name, input logic [fp_add_pkg::word_w-1:0] expected,
                             input logic [fp_add_pkg::word_w-1:0] actual);
      if (actual !== expected) begin
         mismatches++;
         $display("mismatch in %s: expected %h, actual %h", name, expected, actual);
      end
   endtask

   task automatic check_flags(input string name, input fp_add_pkg::fp_flags_t expected,
                              input fp_add_pkg::fp_flags_t actual);
      if (actual !== expected) begin
         mismatches++;
         $display("mismatch in %s flags: expected %b, actual %b", name, expected, actual);
      end
   endtask

   // exact binary32 encoding of an integer below 2^24 in magnitude
   function automatic logic [31:0] int_to_word(input int v);
      int mag;
      int msb;
      logic [31:0] shifted;
      logic [7:0] e;
      mag = (v < 0) ? -v : v;
      if (mag == 0)
         return 32'h0000_0000;
      msb = 0;
      for (int i = 0; i < 24; i++)
         if (mag[i])
            msb = i;
      // hidden bit lands on bit 23 and drops out of the field
      shifted = 32'(mag) << (23 - msb);
      e = 8'(127 + msb);
      return {(v < 0), e, shifted[22:0]};
   endfunction

   // one operation, then wait for its result and compare
   task automatic run_op(input string name, input logic [31:0] a, input logic [31:0] b,
                         input fp_add_pkg::fp_op_e o, input fp_add_pkg::fp_rm_e m,
                         input logic [31:0] exp_word, input fp_add_pkg::fp_flags_t exp_flags);
      int waited;
      @(negedge clk);
      op_a     = a;
      op_b     = b;
      op       = o;
      rm       = m;
      in_valid = 1'b1;
      @(negedge clk);
      in_valid = 1'b0;
      waited   = 0;
      while (!out_valid && waited < 8) begin
         @(negedge clk);
         waited++;
      end
      if (!out_valid) begin
         missing++;
         $display("%s: no out_valid within 8 cycles of the operation", name);
      end else begin
         check_word(name, exp_word, result);
         check_flags(name, exp_flags, flags);
      end
   endtask

   task automatic exact_sums;
      // 1.0 + 2.0 = 3.0
      run_op("one plus two", 32'h3f80_0000, 32'h4000_0000, fp_add_pkg::add, fp_add_pkg::rne,
             32'h4040_0000, flags_none);
      // 5.0 - 1.5 = 3.5
      run_op("five minus 1.5", 32'h40a0_0000, 32'h3fc0_0000, fp_add_pkg::sub, fp_add_pkg::rne,
             32'h4060_0000, flags_none);
      // 100 - 99 = 1, six places of left shift
      run_op("close difference", 32'h42c8_0000, 32'h42c6_0000, fp_add_pkg::sub,
             fp_add_pkg::rne, 32'h3f80_0000, flags_none);
   endtask

   task automatic cancellation;
      logic [31:0] zero_w;
      for (int i = 0; i < 5; i++) begin
         // only round down yields negative zero
         zero_w = (modes[i] == fp_add_pkg::rdn) ? 32'h8000_0000 : 32'h0000_0000;
         run_op($sformatf("cancel rm=%0d", i), 32'h3fc0_0000, 32'h3fc0_0000, fp_add_pkg::sub,
                modes[i], zero_w, flags_none);
      end
      // opposite signs on an add cancel the same way
      run_op("cancel by add", 32'h3fc0_0000, 32'hbfc0_0000, fp_add_pkg::add, fp_add_pkg::rtz,
             32'h0000_0000, flags_none);
   endtask

   task automatic rounding_modes;
      logic sgn;
      logic up;
      logic [31:0] small_w;
      logic [31:0] expect_w;
      for (int s = 0; s < 2; s++)
         for (int k = 0; k < 2; k++)
            for (int i = 0; i < 5; i++) begin
               sgn = s[0];
               // 2^-24 is half an ulp of 1.0, 3*2^-25 is three quarters
               small_w = k[0] ? 32'h33c0_0000 : 32'h3380_0000;
               case (modes[i])
                  // tie goes to the even 1.0, three quarters goes up
                  fp_add_pkg::rne: up = k[0];
                  fp_add_pkg::rtz: up = 1'b0;
                  fp_add_pkg::rdn: up = sgn;
                  fp_add_pkg::rup: up = ~sgn;
                  default:         up = 1'b1;
               endcase
               expect_w = {sgn, 31'h3f80_0000} + {31'd0, up};
               run_op($sformatf("round rm=%0d sign=%0d k=%0d", i, s, k),
                      {sgn, 31'h3f80_0000}, {sgn, small_w[30:0]}, fp_add_pkg::add, modes[i],
                      expect_w, flags_nx);
            end
   endtask

   task automatic range_limits;
      // largest finite doubled
      run_op("overflow pos", 32'h7f7f_ffff, 32'h7f7f_ffff, fp_add_pkg::add, fp_add_pkg::rtz,
             32'h7f80_0000, flags_ovf);
      run_op("overflow neg", 32'hff7f_ffff, 32'hff7f_ffff, fp_add_pkg::add, fp_add_pkg::rne,
             32'hff80_0000, flags_ovf);
      // one ulp above the smallest normal minus the smallest normal
      run_op("underflow pos", 32'h0080_0001, 32'h0080_0000, fp_add_pkg::sub, fp_add_pkg::rne,
             32'h0000_0000, flags_unf);
      run_op("underflow neg", 32'h8080_0001, 32'h8080_0000, fp_add_pkg::sub, fp_add_pkg::rne,
             32'h8000_0000, flags_unf);
   endtask

   task automatic special_values;
      run_op("inf minus inf", 32'h7f80_0000, 32'h7f80_0000, fp_add_pkg::sub, fp_add_pkg::rne,
             fp_add_pkg::canonical_nan, flags_nv);
      // payload is dropped
      run_op("quiet nan", 32'h7fc1_2345, 32'h3f80_0000, fp_add_pkg::add, fp_add_pkg::rne,
             fp_add_pkg::canonical_nan, flags_none);
      run_op("signaling nan", 32'h3f80_0000, 32'h7f80_0001, fp_add_pkg::add, fp_add_pkg::rne,
             fp_add_pkg::canonical_nan, flags_nv);
      run_op("inf plus finite", 32'h7f80_0000, 32'h4000_0000, fp_add_pkg::add, fp_add_pkg::rne,
             32'h7f80_0000, flags_none);
      run_op("neg inf plus finite", 32'hff80_0000, 32'h3f80_0000, fp_add_pkg::add,
             fp_add_pkg::rup, 32'hff80_0000, flags_none);
   endtask

   task automatic back_to_back;
      int a_v [8];
      int b_v [8];
      fp_add_pkg::fp_op_e ops [8];
      logic [31:0] expected [8];
      int r;
      int got;
      int waited;
      for (int i = 0; i < 8; i++) begin
         // integers below 2^20 keep every sum exact
         a_v[i] = ($random(seed) & 32'h000f_ffff) | 32'd1;
         b_v[i] = ($random(seed) & 32'h000f_ffff) | 32'd1;
         r = $random(seed);
         ops[i] = r[20] ? fp_add_pkg::sub : fp_add_pkg::add;
         expected[i] = int_to_word(r[20] ? a_v[i] - b_v[i] : a_v[i] + b_v[i]);
      end
      fork
         begin
            for (int i = 0; i < 8; i++) begin
               @(negedge clk);
               op_a     = int_to_word(a_v[i]);
               op_b     = int_to_word(b_v[i]);
               op       = ops[i];
               rm       = fp_add_pkg::rne;
               in_valid = 1'b1;
            end
            @(negedge clk);
            in_valid = 1'b0;
         end
         begin
            got    = 0;
            waited = 0;
            while (got < 8 && waited < 24) begin
               @(negedge clk);
               waited++;
               if (out_valid) begin
                  check_word($sformatf("pipeline op %0d", got), expected[got], result);
                  check_flags($sformatf("pipeline op %0d", got), flags_none, flags);
                  got++;
               end
            end
            if (got < 8) begin
               missing++;
               $display("pipeline returned only %0d of 8 results", got);
            end
         end
      join
   endtask

   initial begin
      seed     = 43;
      arst_n   = 1'b0;
      in_valid = 1'b0;
      op_a     = '0;
      op_b     = '0;
      op       = fp_add_pkg::add;
      rm       = fp_add_pkg::rne;
      repeat (10) @(posedge clk);
      @(negedge clk);
      arst_n = 1'b1;
      exact_sums();
      cancellation();
      rounding_modes();
      range_limits();
      special_values();
      back_to_back();
      repeat (2) @(negedge clk);
      total = mismatches + missing + DUT.u_props.fail_count;
      $display("errors: %0d mismatches, %0d missing results, %0d assertion failures",
               mismatches, missing, DUT.u_props.fail_count);
      if (total == 0)
         $display("Result: PASSED");
      else
         $display("Result: FAILED");
      $finish;
   end

endmodule

//--- list.f
design/fp_add_pkg.sv
design/fp_align_if.sv
design/fp_sum_if.sv
design/fp_rounder.sv
design/fp_add_decode.sv
design/fp_add_execute.sv
design/fp_add_result.sv
design/fp_add_top.sv
bench/fp_add_properties.sv
bench/fp_add_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build the adder testbench with Verilator, run it and look for the pass line in the log
cd "$(dirname "$0")" &&
rm -f build.log sim.log &&
verilator --binary --assert --timing -f list.f --top-module fp_add_tb \
   -Mdir obj_dir -o fp_add_sim > build.log 2>&1 &&
./obj_dir/fp_add_sim +verilator+error+limit+100 > sim.log 2>&1 &&
grep -q "^Result: PASSED$" sim.log &&
echo "simulation passed, see sim.log" ||
{ echo "simulation failed, see build.log and sim.log"; exit 1; }
